//--- div_pkg.sv
// Divide unit shared definitions
// Word, count and tag widths plus the operation encoding
// for the RISC-V DIV/DIVU/REM/REMU instructions

`default_nettype none

package div_pkg;

    ////////////////////////////////////////////////////////////
    // Widths

    // Operand and result width
    localparam int XLEN = 32;

    // Leading-zero count width, enough for 0..XLEN-1
    localparam int CLZ_W = 5;

    // Instruction tag carried from issue to writeback
    localparam int ID_W = 3;

    ////////////////////////////////////////////////////////////
    // Operation encoding

    // Bit 0 set -> unsigned, bit 1 set -> remainder
    localparam int OP_UNSIGNED_BIT = 0;
    localparam int OP_REM_BIT = 1;

    typedef enum logic [1:0] {
        DIV  = 2'd0,
        DIVU = 2'd1,
        REM  = 2'd2,
        REMU = 2'd3
    } div_op_t;

endpackage

`default_nettype wire

//--- div_clz.sv
// Leading-zero counter
// Combinational priority search for the highest set bit of a word;
// an all-zero word reports the maximum count

`timescale 1ns/1ps
`default_nettype none

module div_clz (
    input  wire logic [div_pkg::XLEN-1:0]  value,
    output logic      [div_pkg::CLZ_W-1:0] count
);

    // Scan upward so the highest set bit wins
    always_comb begin
        // Default covers zero input (and a value of one)
        count = div_pkg::CLZ_W'(div_pkg::XLEN - 1);
        for (int i = 0; i < div_pkg::XLEN; i++) begin
            if (value[i]) begin
                count = div_pkg::CLZ_W'(div_pkg::XLEN - 1 - i);
            end
        end
    end

endmodule

`default_nettype wire

//--- div_core.sv
// Unsigned radix-2 divider core
// Restoring subtract-and-shift, one quotient bit per cycle.
// The divisor is pre-aligned using the leading-zero counts so only
// the significant quotient positions are iterated.

`timescale 1ns/1ps
`default_nettype none

module div_core (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      start,
    input  wire logic [div_pkg::XLEN-1:0]  dividend,
    input  wire logic [div_pkg::XLEN-1:0]  divisor,
    input  wire logic [div_pkg::CLZ_W-1:0] dividend_clz,
    input  wire logic [div_pkg::CLZ_W-1:0] divisor_clz,
    input  wire logic                      divisor_is_zero,
    output logic                           done,
    output logic      [div_pkg::XLEN-1:0]  quotient,
    output logic      [div_pkg::XLEN-1:0]  remainder
);

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        FINISH = 2'd2
    } state_t;

    state_t state;

    // Working registers
    logic [div_pkg::XLEN-1:0]  rem_q;
    logic [div_pkg::XLEN-1:0]  quo_q;
    logic [div_pkg::XLEN-1:0]  div_shift;
    logic [div_pkg::CLZ_W-1:0] pos_q;

    logic [div_pkg::CLZ_W-1:0] shift_amt;
    logic                      early_exit;
    logic [div_pkg::XLEN:0]    sub_result;
    logic                      step_ok;

    ////////////////////////////////////////////////////////////
    // Alignment and trial subtract

    // Quotient has at most shift_amt+1 significant bits
    assign shift_amt  = divisor_clz - dividend_clz;
    // Divisor larger than dividend, or zero: nothing to iterate
    assign early_exit = divisor_is_zero | (divisor_clz < dividend_clz);

    // Borrow out of the extra top bit means the step fails
    assign sub_result = {1'b0, rem_q} - {1'b0, div_shift};
    assign step_ok    = ~sub_result[div_pkg::XLEN];

    ////////////////////////////////////////////////////////////
    // Control FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else if (start) begin
            state <= early_exit ? FINISH : RUN;
        end else begin
            case (state)
                RUN: begin
                    // Last position just processed
                    if (pos_q == '0) begin
                        state <= FINISH;
                    end
                end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Datapath

    always_ff @(posedge clk) begin
        if (start) begin
            // Early exit leaves quotient 0, remainder = dividend
            rem_q     <= dividend;
            quo_q     <= '0;
            div_shift <= divisor << shift_amt;
            pos_q     <= shift_amt;
        end else if (state == RUN) begin
            if (step_ok) begin
                rem_q <= sub_result[div_pkg::XLEN-1:0];
            end
            // New quotient bit enters at the bottom
            quo_q     <= {quo_q[div_pkg::XLEN-2:0], step_ok};
            div_shift <= div_shift >> 1;
            pos_q     <= pos_q - 1'b1;
        end
    end

    // Single-cycle done, results held until next start
    assign done      = (state == FINISH);
    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

`default_nettype wire

//--- div_reuse_detect.sv
// Divide result reuse detector
// Remembers operands and signedness of the last accepted operation
// and flags an incoming one whose result the divider already holds

`timescale 1ns/1ps
`default_nettype none

module div_reuse_detect (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     issue_valid,
    input  wire logic                     issue_ready,
    input  wire div_pkg::div_op_t         issue_op,
    input  wire logic [div_pkg::XLEN-1:0] issue_rs1,
    input  wire logic [div_pkg::XLEN-1:0] issue_rs2,
    output logic                          reuse
);

    logic [div_pkg::XLEN-1:0] last_rs1;
    logic [div_pkg::XLEN-1:0] last_rs2;
    logic                     last_signed;
    logic                     last_valid;

    logic issue_signed;
    logic accept;

    assign issue_signed = ~issue_op[div_pkg::OP_UNSIGNED_BIT];
    assign accept       = issue_valid & issue_ready;

    // Record only means something once an op went through
    always_ff @(posedge clk) begin
        if (rst) begin
            last_valid <= 1'b0;
        end else if (accept) begin
            last_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            last_rs1    <= issue_rs1;
            last_rs2    <= issue_rs2;
            last_signed <= issue_signed;
        end
    end

    // Same magnitudes and signs, so quotient and remainder both match
    assign reuse = last_valid
                 & (issue_rs1 == last_rs1)
                 & (issue_rs2 == last_rs2)
                 & (issue_signed == last_signed);

endmodule

`default_nettype wire

//--- div_unit.sv
// Integer divide unit
// Converts operands to magnitudes, buffers one waiting operation,
// runs the unsigned core and applies the RISC-V sign and
// divide-by-zero rules on the way back to writeback

`timescale 1ns/1ps
`default_nettype none

module div_unit (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     issue_valid,
    input  wire div_pkg::div_op_t         issue_op,
    input  wire logic [div_pkg::XLEN-1:0] issue_rs1,
    input  wire logic [div_pkg::XLEN-1:0] issue_rs2,
    input  wire logic [div_pkg::ID_W-1:0] issue_id,
    input  wire logic                     reuse,
    output logic                          issue_ready,
    input  wire logic                     wb_ack,
    output logic                          wb_done,
    output logic      [div_pkg::XLEN-1:0] wb_rd,
    output logic      [div_pkg::ID_W-1:0] wb_id
);

    // Conditional two's complement
    function automatic logic [div_pkg::XLEN-1:0] negate_if(
        input logic [div_pkg::XLEN-1:0] a,
        input logic                     neg
    );
        return ({div_pkg::XLEN{neg}} ^ a) + div_pkg::XLEN'(neg);
    endfunction

    // Issue-side decode
    logic                      signed_op;
    logic                      neg_dividend;
    logic                      neg_divisor;
    logic [div_pkg::XLEN-1:0]  mag_dividend;
    logic [div_pkg::XLEN-1:0]  mag_divisor;
    logic [div_pkg::CLZ_W-1:0] dividend_clz;
    logic [div_pkg::CLZ_W-1:0] divisor_clz;

    // Input buffer, one entry
    logic                      buf_valid;
    logic [div_pkg::XLEN-1:0]  buf_dividend;
    logic [div_pkg::XLEN-1:0]  buf_divisor;
    logic [div_pkg::CLZ_W-1:0] buf_dividend_clz;
    logic [div_pkg::CLZ_W-1:0] buf_divisor_clz;
    logic                      buf_rem_op;
    logic                      buf_neg_rem;
    logic                      buf_neg_quo;
    logic                      buf_div_zero;
    logic                      buf_reuse;
    logic [div_pkg::ID_W-1:0]  buf_id;

    // Attributes of the operation in progress
    logic                      in_progress;
    logic                      ip_rem_op;
    logic                      ip_neg_rem;
    logic                      ip_neg_quo;
    logic                      ip_div_zero;
    logic [div_pkg::ID_W-1:0]  ip_id;

    logic                      push;
    logic                      pop;
    logic                      unit_free;
    logic                      core_start;
    logic                      core_done;
    logic                      unit_done;
    logic [div_pkg::XLEN-1:0]  core_quotient;
    logic [div_pkg::XLEN-1:0]  core_remainder;
    logic [div_pkg::XLEN-1:0]  raw_result;
    logic                      neg_result;

    ////////////////////////////////////////////////////////////
    // Sign handling and magnitudes

    assign signed_op    = ~issue_op[div_pkg::OP_UNSIGNED_BIT];
    assign neg_dividend = signed_op & issue_rs1[div_pkg::XLEN-1];
    assign neg_divisor  = signed_op & issue_rs2[div_pkg::XLEN-1];

    assign mag_dividend = negate_if(issue_rs1, neg_dividend);
    assign mag_divisor  = negate_if(issue_rs2, neg_divisor);

    div_clz u_dividend_clz (
        .value (mag_dividend),
        .count (dividend_clz)
    );

    div_clz u_divisor_clz (
        .value (mag_divisor),
        .count (divisor_clz)
    );

    ////////////////////////////////////////////////////////////
    // Input buffer

    // Room when empty, or when the held entry leaves this cycle
    assign issue_ready = ~buf_valid | ~in_progress;
    assign push        = issue_valid & issue_ready;
    assign unit_free   = ~in_progress | wb_ack;
    assign pop         = buf_valid & unit_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (push) begin
            buf_valid <= 1'b1;
        end else if (pop) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_dividend     <= mag_dividend;
            buf_divisor      <= mag_divisor;
            buf_dividend_clz <= dividend_clz;
            buf_divisor_clz  <= divisor_clz;
            buf_rem_op       <= issue_op[div_pkg::OP_REM_BIT];
            // Remainder takes the dividend's sign
            buf_neg_rem      <= neg_dividend;
            buf_neg_quo      <= neg_dividend ^ neg_divisor;
            // Count saturates for both 0 and 1, low bit separates them
            buf_div_zero     <= (&divisor_clz) & ~mag_divisor[0];
            buf_reuse        <= reuse;
            buf_id           <= issue_id;
        end
    end

    ////////////////////////////////////////////////////////////
    // Progress tracking

    assign core_start = pop & ~buf_reuse;
    // Reused result is already sitting in the core
    assign unit_done  = core_done | (pop & buf_reuse);

    // Set wins over clear
    always_ff @(posedge clk) begin
        if (rst) begin
            in_progress <= 1'b0;
        end else if (pop) begin
            in_progress <= 1'b1;
        end else if (wb_ack) begin
            in_progress <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            ip_rem_op   <= buf_rem_op;
            ip_neg_rem  <= buf_neg_rem;
            ip_neg_quo  <= buf_neg_quo;
            ip_div_zero <= buf_div_zero;
            ip_id       <= buf_id;
        end
    end

    div_core u_core (
        .clk             (clk),
        .rst             (rst),
        .start           (core_start),
        .dividend        (buf_dividend),
        .divisor         (buf_divisor),
        .dividend_clz    (buf_dividend_clz),
        .divisor_clz     (buf_divisor_clz),
        .divisor_is_zero (buf_div_zero),
        .done            (core_done),
        .quotient        (core_quotient),
        .remainder       (core_remainder)
    );

    ////////////////////////////////////////////////////////////
    // Result and writeback

    // Divide by zero forces an all-ones quotient, never negated
    assign raw_result = ip_rem_op ? core_remainder
                                  : ({div_pkg::XLEN{ip_div_zero}} | core_quotient);
    assign neg_result = ip_rem_op ? ip_neg_rem : (ip_neg_quo & ~ip_div_zero);

    assign wb_rd = negate_if(raw_result, neg_result);
    assign wb_id = ip_id;

    // Level held until acknowledged
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_done <= 1'b0;
        end else begin
            wb_done <= (wb_done & ~wb_ack) | unit_done;
        end
    end

endmodule

`default_nettype wire

//--- div_top.sv
// Divide unit top level
// Joins the reuse detector to the divide unit; issue and
// writeback ports pass straight through

`timescale 1ns/1ps
`default_nettype none

module div_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     issue_valid,
    input  wire div_pkg::div_op_t         issue_op,
    input  wire logic [div_pkg::XLEN-1:0] issue_rs1,
    input  wire logic [div_pkg::XLEN-1:0] issue_rs2,
    input  wire logic [div_pkg::ID_W-1:0] issue_id,
    output logic                          issue_ready,
    input  wire logic                     wb_ack,
    output logic                          wb_done,
    output logic      [div_pkg::XLEN-1:0] wb_rd,
    output logic      [div_pkg::ID_W-1:0] wb_id
);

    // Same-operand hint, valid in the issue cycle
    logic reuse;

    div_reuse_detect u_reuse (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .reuse       (reuse)
    );

    div_unit u_unit (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_id    (issue_id),
        .reuse       (reuse),
        .issue_ready (issue_ready),
        .wb_ack      (wb_ack),
        .wb_done     (wb_done),
        .wb_rd       (wb_rd),
        .wb_id       (wb_id)
    );

endmodule

`default_nettype wire

//--- div_tb.sv
// Divide unit testbench
// Directed and random checks of DIV/DIVU/REM/REMU through div_top
// against a reference model of the RISC-V divide rules

`timescale 1ns/1ps
`default_nettype none

module div_tb;

    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 10;
    localparam int RANDOM_OPS   = 200;
    // Issued per test: basic 24, edges 14, reuse 8, back-pressure 3
    localparam int NUM_OPS        = 24 + 14 + 8 + 3 + RANDOM_OPS;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 40 * NUM_OPS;
    localparam logic [31:0] SEED  = 32'hfbfd;

    // Dividend/divisor pairs, every sign combination plus large magnitudes
    localparam logic [31:0] BASIC_A [6] = '{32'd100, 32'(-100), 32'd100, 32'(-100),
                                            32'hffff_fff0, 32'h7fff_ffff};
    localparam logic [31:0] BASIC_B [6] = '{32'd7, 32'd7, 32'(-7), 32'(-7),
                                            32'd3, 32'h0000_0010};

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     issue_valid;
    div_pkg::div_op_t         issue_op;
    logic [div_pkg::XLEN-1:0] issue_rs1;
    logic [div_pkg::XLEN-1:0] issue_rs2;
    logic [div_pkg::ID_W-1:0] issue_id;
    logic                     issue_ready;
    logic                     wb_ack = 1'b0;
    logic                     wb_done;
    logic [div_pkg::XLEN-1:0] wb_rd;
    logic [div_pkg::ID_W-1:0] wb_id;

    // Scoreboard in issue order
    logic [31:0]              rd_q [$];
    logic [div_pkg::ID_W-1:0] id_q [$];
    logic [div_pkg::ID_W-1:0] next_id = '0;

    // Writeback ack control
    logic        ack_enable    = 1'b1;
    int          ack_delay_max = 0;
    int          ack_wait      = 0;
    int          cycle_count   = 0;

    div_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_id    (issue_id),
        .issue_ready (issue_ready),
        .wb_ack      (wb_ack),
        .wb_done     (wb_done),
        .wb_rd       (wb_rd),
        .wb_id       (wb_id)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model and checking

    function automatic logic [31:0] expected_result(input div_pkg::div_op_t op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               overflow;
        logic [31:0]        result;
        sa = a;
        sb = b;
        // Most negative value over minus one
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            div_pkg::DIV: begin
                if (b == '0) begin
                    result = 32'hffff_ffff;
                end else if (overflow) begin
                    result = a;
                end else begin
                    // Truncating signed divide
                    result = sa / sb;
                end
            end
            div_pkg::DIVU: result = (b == '0) ? 32'hffff_ffff : a / b;
            div_pkg::REM: begin
                if (b == '0) begin
                    result = a;
                end else if (overflow) begin
                    result = '0;
                end else begin
                    // Sign follows the dividend
                    result = sa % sb;
                end
            end
            default:       result = (b == '0) ? a : a % b;
        endcase
        return result;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("error %s got %h expected %h", name, got, want));
        end
    endtask

    // Watchdog on total run length
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles, results still pending",
                                cycle_count));
        end
    end

    // Writeback monitor, acks after a random delay and checks on the ack edge
    always @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else if (wb_ack) begin
            if (rd_q.size() == 0) begin
                abort_run("result written back with no operation outstanding");
            end
            check_value("wb_done", 32'(wb_done), 32'd1);
            check_value("wb_rd", wb_rd, rd_q.pop_front());
            check_value("wb_id", 32'(wb_id), 32'(id_q.pop_front()));
            wb_ack <= 1'b0;
            ack_wait = $urandom_range(0, ack_delay_max);
        end else if (wb_done && ack_enable) begin
            if (ack_wait == 0) begin
                wb_ack <= 1'b1;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Issue side

    task automatic send_op(input div_pkg::div_op_t op, input logic [31:0] a,
                           input logic [31:0] b);
        // Ready only falls after a push, so a high sample holds into the next cycle
        @(posedge clk);
        while (!issue_ready) begin
            @(posedge clk);
        end
        issue_valid <= 1'b1;
        issue_op    <= op;
        issue_rs1   <= a;
        issue_rs2   <= b;
        issue_id    <= next_id;
        rd_q.push_back(expected_result(op, a, b));
        id_q.push_back(next_id);
        next_id = next_id + div_pkg::ID_W'(1);
        @(posedge clk);
        check_value("issue_ready", 32'(issue_ready), 32'd1);
        issue_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        while (rd_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic send_all_ops(input logic [31:0] a, input logic [31:0] b);
        // DIV, DIVU, REM, REMU alternate signedness, so no reuse here
        for (int k = 0; k < 4; k++) begin
            send_op(div_pkg::div_op_t'(2'(k)), a, b);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests

    task automatic check_after_reset();
        @(posedge clk);
        check_value("wb_done", 32'(wb_done), 32'd0);
        check_value("issue_ready", 32'(issue_ready), 32'd1);
    endtask

    task automatic cover_basic_ops();
        for (int i = 0; i < 6; i++) begin
            send_all_ops(BASIC_A[i], BASIC_B[i]);
        end
        wait_idle();
    endtask

    task automatic cover_edge_cases();
        // Zero divisor
        send_all_ops(32'(-5), 32'd0);
        // Signed overflow
        send_all_ops(32'h8000_0000, 32'hffff_ffff);
        // Divisor above dividend, early exit in the core
        send_all_ops(32'd5, 32'd100);
        send_op(div_pkg::DIV, 32'(-5), 32'd100);
        send_op(div_pkg::REM, 32'(-5), 32'd100);
        wait_idle();
    endtask

    task automatic reuse_pairs();
        send_op(div_pkg::DIV, 32'(-1234567), 32'd89);
        send_op(div_pkg::REM, 32'(-1234567), 32'd89);
        send_op(div_pkg::DIVU, 32'hdead_beef, 32'h0000_1234);
        send_op(div_pkg::REMU, 32'hdead_beef, 32'h0000_1234);
        send_op(div_pkg::REM, 32'd7777, 32'(-33));
        send_op(div_pkg::DIV, 32'd7777, 32'(-33));
        // Signedness differs, needs a fresh division
        send_op(div_pkg::DIV, 32'(-50), 32'd7);
        send_op(div_pkg::DIVU, 32'(-50), 32'd7);
        wait_idle();
    endtask

    task automatic backpressure_hold();
        logic [31:0]              held_rd;
        logic [div_pkg::ID_W-1:0] held_id;
        @(negedge clk);
        ack_enable = 1'b0;
        send_op(div_pkg::DIV, 32'h7fff_ffff, 32'd3);
        send_op(div_pkg::REMU, 32'h0012_3456, 32'd10);
        // One in the core, one waiting
        @(posedge clk);
        check_value("issue_ready", 32'(issue_ready), 32'd0);
        while (!wb_done) begin
            @(posedge clk);
        end
        held_rd = wb_rd;
        held_id = wb_id;
        check_value("wb_rd", held_rd, rd_q[0]);
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            check_value("wb_done", 32'(wb_done), 32'd1);
            check_value("wb_rd", wb_rd, held_rd);
            check_value("wb_id", 32'(wb_id), 32'(held_id));
            check_value("issue_ready", 32'(issue_ready), 32'd0);
        end
        @(negedge clk);
        ack_enable = 1'b1;
        send_op(div_pkg::DIVU, 32'h0000_0100, 32'd3);
        wait_idle();
    endtask

    task automatic random_stream();
        logic [31:0]      a;
        logic [31:0]      b;
        div_pkg::div_op_t op;
        int               kind;
        a = $urandom;
        b = $urandom;
        @(negedge clk);
        ack_delay_max = 3;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            kind = $urandom_range(0, 7);
            op   = div_pkg::div_op_t'(2'($urandom_range(0, 3)));
            case (kind)
                // Operands kept from the previous op
                0: ;
                1: begin
                    a = $urandom;
                    b = '0;
                end
                2: begin
                    a = $urandom;
                    b = $urandom_range(1, 255);
                end
                3: begin
                    a = 32'h8000_0000;
                    b = 32'hffff_ffff;
                end
                default: begin
                    a = $urandom;
                    b = $urandom >> $urandom_range(0, 31);
                end
            endcase
            send_op(op, a, b);
        end
        wait_idle();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_op    = div_pkg::DIV;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_id    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        check_after_reset();
        cover_basic_ops();
        cover_edge_cases();
        reuse_pairs();
        backpressure_hold();
        random_stream();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- div_top.f
div_pkg.sv
div_clz.sv
div_core.sv
div_reuse_detect.sv
div_unit.sv
div_top.sv
div_tb.sv

//--- Makefile
# Verilator build and run for the divide unit testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= div_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Result is taken from the log, not from the exit status
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^=== PASS ===$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
